//--- build.f
+incdir+dv
rtl/memAccessPkg.sv
rtl/memoryAddressHandler.sv
rtl/opRequestPort.sv
rtl/accessCore.sv
rtl/byteLaneMemory.sv
rtl/memAccessTop.sv
dv/memAccessTb.sv

//--- dv/memAccessModel.svh
`ifndef MEM_ACCESS_MODEL_SVH
`define MEM_ACCESS_MODEL_SVH

  localparam int StackSize = 6;

  logic [7:0] modelMem [MemDepth];
  int         stackDepth [2]; // Items held per mode, 0 when empty

  // Address of the top item when the stack holds depth items
  function automatic memAddr_t stackTopAddr(input logic m, input int depth);
    word_t regionEnd;
    regionEnd = m ? PrivStackEnd : UserStackEnd;
    return memAddr_t'(regionEnd - word_t'(depth - 1));
  endfunction

  function automatic int widthOf(input memOp_t o);
    case (o)
      opByte:  return 1;
      opHalf:  return 2;
      opWord:  return 4;
      default: return 0;
    endcase
  endfunction

  // Applies one operation and gives the expected response
  function automatic void modelStep(input memOp_t o, input logic m, input logic w,
                                    input word_t addr, input word_t data,
                                    output word_t rd, output logic flt, output int lanes);
    memAddr_t a;
    int       k;
    rd    = '0;
    flt   = 1'b0;
    lanes = 0;
    case (o)
      opPush: begin
        if (stackDepth[m] == StackSize) begin
          flt = 1'b1; // Full, nothing moves
        end else begin
          stackDepth[m] = stackDepth[m] + 1;
          modelMem[stackTopAddr(m, stackDepth[m])] = data[7:0];
          lanes = 1;
        end
      end
      opPop: begin
        if (stackDepth[m] == 0) begin
          flt = 1'b1;
        end else begin
          rd[7:0]       = modelMem[stackTopAddr(m, stackDepth[m])];
          stackDepth[m] = stackDepth[m] - 1;
          lanes = 1;
        end
      end
      opByte, opHalf, opWord: begin
        lanes = widthOf(o);
        for (k = 0; k < lanes; k++) begin
          a = memAddr_t'(addr) - memAddr_t'(k); // Lanes descend in address
          if (w) modelMem[a] = data[8*k +: 8];
          else   rd[8*k +: 8] = modelMem[a];
        end
      end
      default: lanes = 0;
    endcase
  endfunction

`endif

//--- dv/memAccessTb.sv
`timescale 1ns/1ps

module memAccessTb;

  import memAccessPkg::*;

  localparam int NumRoundTrip = 48;
  localparam int NumStack     = 80;
  localparam int NumFaultOps  = 40; // Upper bound for the fault sequence
  localparam int NumNoneOps   = 4;
  localparam int NumMixed     = 400;
  localparam int TotalOps     = NumRoundTrip + NumStack + NumFaultOps + NumNoneOps + NumMixed;
  localparam int CycleLimit   = 12 * TotalOps + 100;

  logic   clk;
  logic   rst;
  logic   req;
  logic   ack;
  memOp_t op;
  logic   mode;
  logic   write;
  word_t  resultAddress;
  word_t  writeData;
  word_t  readData;
  logic   stackFault;

  int dataErrors;
  int flagErrors;
  int latencyErrors;
  int cycleCount;
  int seedInit;

  // Earlier stores, so loads only hit written bytes
  word_t  storeAddrs[$];
  memOp_t storeOps[$];

  `include "memAccessModel.svh"

  memAccessTop dut_i (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .ack           (ack),
    .op            (op),
    .mode          (mode),
    .write         (write),
    .resultAddress (resultAddress),
    .writeData     (writeData),
    .readData      (readData),
    .stackFault    (stackFault)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout after %0d cycles, the run hung waiting on the handshake", cycleCount);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic checkWord(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      dataErrors++;
      $display("ERROR t=%0t %s: expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic checkFault(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      flagErrors++;
      $display("ERROR t=%0t %s: expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic checkLatency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      latencyErrors++;
      $display("ERROR t=%0t %s: expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  // One four-phase transaction, entered and left at a falling edge
  task automatic runOp(input memOp_t opIn, input logic modeIn, input logic writeIn,
                       input word_t addrIn, input word_t dataIn);
    word_t expData;
    logic  expFault;
    int    lanes;
    int    cycles;
    int    holdCycles;
    logic  isLoad;
    modelStep(opIn, modeIn, writeIn, addrIn, dataIn, expData, expFault, lanes);
    isLoad = !writeIn && (opIn == opByte || opIn == opHalf || opIn == opWord);
    @(posedge clk);
    op            <= opIn;
    mode          <= modeIn;
    write         <= writeIn;
    resultAddress <= addrIn;
    writeData     <= dataIn;
    req           <= 1'b1;
    @(negedge clk);
    checkFault("ack", 1'b0, ack); // req raised but not yet sampled
    @(posedge clk); // First edge that samples req
    cycles = 0;
    @(negedge clk);
    while (!ack) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end
    checkLatency("ack latency", lanes + 2, cycles);
    checkFault("stackFault", expFault, stackFault);
    if (!expFault && (opIn == opPop || isLoad)) checkWord("readData", expData, readData);
    holdCycles = $urandom % 3;
    repeat (holdCycles) begin
      @(posedge clk);
      @(negedge clk);
      checkFault("ack", 1'b1, ack); // Held while req stays high
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    checkFault("ack", 1'b1, ack); // req low but not yet sampled
    @(posedge clk); // Samples req low
    @(negedge clk);
    checkFault("ack", 1'b0, ack);
  endtask

  task automatic randomStore();
    memOp_t o;
    word_t  a;
    o = memOp_t'(3 + $urandom % 3);
    a = 3 + $urandom % 1021;
    runOp(o, $urandom % 2, 1'b1, a, $urandom);
    storeAddrs.push_back(a);
    storeOps.push_back(o);
  endtask

  // Same address and width as an earlier store
  task automatic randomLoad();
    int idx;
    idx = $urandom % storeAddrs.size();
    runOp(storeOps[idx], $urandom % 2, 1'b0, storeAddrs[idx], $urandom);
  endtask

  task automatic randomStackOp();
    logic m;
    m = $urandom % 2;
    if ($urandom % 2) runOp(opPush, m, $urandom % 2, $urandom, $urandom);
    else              runOp(opPop, m, $urandom % 2, $urandom, $urandom);
  endtask

  initial begin
    int kind;
    seedInit      = $urandom(32'h1b41);
    clk           = 1'b0;
    rst           = 1'b1;
    req           = 1'b0;
    op            = opNone;
    mode          = 1'b0;
    write         = 1'b0;
    resultAddress = '0;
    writeData     = '0;
    dataErrors    = 0;
    flagErrors    = 0;
    latencyErrors = 0;
    cycleCount    = 0;
    stackDepth[0] = 0;
    stackDepth[1] = 0;

    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Quiet bus after reset
    repeat (3) begin
      @(negedge clk);
      checkFault("ack", 1'b0, ack);
      checkFault("stackFault", 1'b0, stackFault);
      checkWord("readData", '0, readData);
    end

    repeat (NumRoundTrip / 2) randomStore();
    repeat (NumRoundTrip / 2) randomLoad();

    repeat (NumStack) randomStackOp();

    // Drain, underflow, fill, overflow, then unwind per mode
    for (int m = 0; m < 2; m++) begin
      while (stackDepth[m] > 0) runOp(opPop, m, 1'b0, '0, '0);
      runOp(opPop, m, 1'b0, '0, '0);
      repeat (StackSize + 1) runOp(opPush, m, 1'b0, '0, $urandom);
      repeat (StackSize) runOp(opPop, m, 1'b0, '0, '0);
    end

    repeat (NumNoneOps) runOp(opNone, $urandom % 2, $urandom % 2, $urandom, $urandom);

    repeat (NumMixed) begin
      kind = $urandom % 10;
      if (kind < 5)      randomStackOp();
      else if (kind < 7) randomStore();
      else if (kind < 9) randomLoad();
      else               runOp(opNone, $urandom % 2, $urandom % 2, $urandom, $urandom);
    end

    $display("Summary: %0d data errors, %0d flag errors, %0d latency errors",
             dataErrors, flagErrors, latencyErrors);
    if (dataErrors + flagErrors + latencyErrors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- rtl/accessCore.sv
`timescale 1ns/1ps

module accessCore (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  memAccessPkg::memOp_t     op,
  input  logic                     mode,
  input  logic                     write,
  input  memAccessPkg::word_t      address,
  input  memAccessPkg::word_t      writeData,
  output logic                     done,
  output memAccessPkg::word_t      readData,
  output logic                     fault,
  output logic                     memStart,
  output memAccessPkg::laneAddrs_t laneAddrs,
  output memAccessPkg::laneCount_t laneCount,
  output logic                     memWrite,
  output memAccessPkg::word_t      memWriteData,
  input  logic                     memDone,
  input  memAccessPkg::word_t      memReadData
);

  import memAccessPkg::*;

  word_t userSp;
  word_t privSp;
  word_t spSel;
  word_t spNext;
  logic  hFault;
  logic  skip;
  logic  skipDone;

  assign spSel = mode ? privSp : userSp;

  memoryAddressHandler addrHandler_i (
    .op            (op),
    .mode          (mode),
    .sp            (spSel),
    .resultAddress (address),
    .laneAddrs     (laneAddrs),
    .laneCount     (laneCount),
    .spNext        (spNext),
    .fault         (hFault)
  );

  // Faulted jobs and opNone never reach the memory
  assign skip     = hFault || (op == opNone);
  assign memStart = start && !skip;

  always_comb begin
    case (op)
      opPush:  memWrite = 1'b1;
      opPop:   memWrite = 1'b0;
      default: memWrite = write;
    endcase
  end

  assign memWriteData = writeData; // Pushed byte rides in lane 0
  assign readData     = memReadData;
  assign done         = memDone || skipDone;

  always_ff @(posedge clk) begin
    if (rst) begin
      userSp   <= SpEmpty;
      privSp   <= SpEmpty;
      skipDone <= 1'b0;
      fault    <= 1'b0;
    end else begin
      skipDone <= start && skip;
      if (start) begin
        fault <= hFault; // Sampled before the pointer moves
        if (!hFault) begin
          if (mode) privSp <= spNext;
          else      userSp <= spNext;
        end
      end
    end
  end

endmodule

//--- rtl/byteLaneMemory.sv
`timescale 1ns/1ps

module byteLaneMemory (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     memStart,
  input  memAccessPkg::laneAddrs_t laneAddrs,
  input  memAccessPkg::laneCount_t laneCount,
  input  logic                     memWrite,
  input  memAccessPkg::word_t      memWriteData,
  output logic                     memDone,
  output memAccessPkg::word_t      memReadData
);

  import memAccessPkg::*;

  typedef enum logic {idle, run} memState_t;

  memState_t  state;
  logic [1:0] laneIdx;
  logic       lastLane;

  // Latched job
  laneAddrs_t jobAddrs;
  laneCount_t jobCount;
  logic       jobWrite;
  word_t      jobData;
  memAddr_t   curAddr;

  logic [7:0] mem [MemDepth];

  assign curAddr  = jobAddrs[10*laneIdx +: 10];
  assign lastLane = ({1'b0, laneIdx} == jobCount - 3'd1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= idle;
      laneIdx <= 2'd0;
      memDone <= 1'b0;
    end else begin
      memDone <= 1'b0;
      case (state)
        idle: if (memStart) begin
          state   <= run;
          laneIdx <= 2'd0;
        end
        run: begin
          if (lastLane) begin
            memDone <= 1'b1;
            state   <= idle;
          end else begin
            laneIdx <= laneIdx + 2'd1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && memStart) begin
      jobAddrs    <= laneAddrs;
      jobCount    <= laneCount;
      jobWrite    <= memWrite;
      jobData     <= memWriteData;
      memReadData <= '0; // Unused upper bytes read as zero
    end else if (state == run) begin
      // One byte per cycle, lane k on bits 8k+7..8k
      if (jobWrite) mem[curAddr] <= jobData[8*laneIdx +: 8];
      else          memReadData[8*laneIdx +: 8] <= mem[curAddr];
    end
  end

endmodule

//--- rtl/memAccessPkg.sv
package memAccessPkg;

  // Operation codes, same encoding as the control unit
  typedef enum logic [2:0] {
    opNone = 3'd0,
    opPush = 3'd1,
    opPop  = 3'd2,
    opByte = 3'd3,
    opHalf = 3'd4,
    opWord = 3'd5
  } memOp_t;

  typedef logic [31:0] word_t;      // Data or address word
  typedef logic [9:0]  memAddr_t;   // Byte address into the memory
  typedef logic [39:0] laneAddrs_t; // Four lane addresses, lane 0 lowest
  typedef logic [2:0]  laneCount_t; // Lanes per job, 1 to 4

  // Stack regions, inclusive bounds
  localparam word_t UserStackStart = 32'd101;
  localparam word_t UserStackEnd   = 32'd106;
  localparam word_t PrivStackStart = 32'd107;
  localparam word_t PrivStackEnd   = 32'd112;

  // Pointer value of an empty stack
  localparam word_t SpEmpty = 32'hffff_ffff;

  localparam int MemDepth = 1024;

endpackage

//--- rtl/memAccessTop.sv
`timescale 1ns/1ps

module memAccessTop (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  output logic                 ack,
  input  memAccessPkg::memOp_t op,
  input  logic                 mode,
  input  logic                 write,
  input  memAccessPkg::word_t  resultAddress,
  input  memAccessPkg::word_t  writeData,
  output memAccessPkg::word_t  readData,
  output logic                 stackFault
);

  import memAccessPkg::*;

  // Port to core
  logic   start;
  logic   done;
  logic   coreFault;
  memOp_t capOp;
  logic   capMode;
  logic   capWrite;
  word_t  capAddress;
  word_t  capWriteData;
  word_t  coreReadData;

  // Core to memory
  logic       memStart;
  logic       memDone;
  logic       memWrite;
  laneAddrs_t laneAddrs;
  laneCount_t laneCount;
  word_t      memWriteData;
  word_t      memReadData;

  opRequestPort reqPort_i (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .ack          (ack),
    .op           (op),
    .mode         (mode),
    .write        (write),
    .resultAddress(resultAddress),
    .writeData    (writeData),
    .readData     (readData),
    .stackFault   (stackFault),
    .start        (start),
    .capOp        (capOp),
    .capMode      (capMode),
    .capWrite     (capWrite),
    .capAddress   (capAddress),
    .capWriteData (capWriteData),
    .done         (done),
    .coreReadData (coreReadData),
    .coreFault    (coreFault)
  );

  accessCore core_i (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .op           (capOp),
    .mode         (capMode),
    .write        (capWrite),
    .address      (capAddress),
    .writeData    (capWriteData),
    .done         (done),
    .readData     (coreReadData),
    .fault        (coreFault),
    .memStart     (memStart),
    .laneAddrs    (laneAddrs),
    .laneCount    (laneCount),
    .memWrite     (memWrite),
    .memWriteData (memWriteData),
    .memDone      (memDone),
    .memReadData  (memReadData)
  );

  byteLaneMemory mem_i (
    .clk          (clk),
    .rst          (rst),
    .memStart     (memStart),
    .laneAddrs    (laneAddrs),
    .laneCount    (laneCount),
    .memWrite     (memWrite),
    .memWriteData (memWriteData),
    .memDone      (memDone),
    .memReadData  (memReadData)
  );

endmodule

//--- rtl/memoryAddressHandler.sv
`timescale 1ns/1ps

module memoryAddressHandler (
  input  memAccessPkg::memOp_t     op,
  input  logic                    mode,
  input  memAccessPkg::word_t     sp,
  input  memAccessPkg::word_t     resultAddress,
  output memAccessPkg::laneAddrs_t laneAddrs,
  output memAccessPkg::laneCount_t laneCount,
  output memAccessPkg::word_t     spNext,
  output logic                    fault
);

  import memAccessPkg::*;

  word_t    regionStart;
  word_t    regionEnd;
  memAddr_t baseAddr;
  memAddr_t lane0;

  // Mode 1 selects the privileged stack
  assign regionStart = mode ? PrivStackStart : UserStackStart;
  assign regionEnd   = mode ? PrivStackEnd : UserStackEnd;
  assign baseAddr    = resultAddress[9:0];

  always_comb begin
    spNext    = sp;
    lane0     = '0;
    laneAddrs = '0;
    laneCount = 3'd0;
    fault     = 1'b0;

    case (op)
      opPush: begin
        if (sp == SpEmpty) begin
          // First item lands at the top of the region
          lane0     = regionEnd[9:0];
          spNext    = regionEnd;
          laneCount = 3'd1;
        end else if (sp > regionStart && sp <= regionEnd) begin
          lane0     = memAddr_t'(sp - 32'd1);
          spNext    = sp - 32'd1;
          laneCount = 3'd1;
        end else begin
          fault = 1'b1; // Full
        end
        laneAddrs[9:0] = lane0;
      end

      opPop: begin
        if (sp >= regionStart && sp < regionEnd) begin
          lane0     = sp[9:0];
          spNext    = sp + 32'd1;
          laneCount = 3'd1;
        end else if (sp == regionEnd) begin
          // Last item, stack goes back to empty
          lane0     = regionEnd[9:0];
          spNext    = SpEmpty;
          laneCount = 3'd1;
        end else begin
          fault = 1'b1; // Empty
        end
        laneAddrs[9:0] = lane0;
      end

      opByte: begin
        laneAddrs[9:0] = baseAddr;
        laneCount      = 3'd1;
      end

      opHalf: begin
        laneAddrs[9:0]   = baseAddr;
        laneAddrs[19:10] = baseAddr - 10'd1;
        laneCount        = 3'd2;
      end

      opWord: begin
        // Lanes descend from the result address
        laneAddrs[9:0]   = baseAddr;
        laneAddrs[19:10] = baseAddr - 10'd1;
        laneAddrs[29:20] = baseAddr - 10'd2;
        laneAddrs[39:30] = baseAddr - 10'd3;
        laneCount        = 3'd4;
      end

      default: laneCount = 3'd0; // opNone touches nothing
    endcase
  end

endmodule

//--- rtl/opRequestPort.sv
`timescale 1ns/1ps

module opRequestPort (
  input  logic                clk,
  input  logic                rst,
  input  logic                req,
  output logic                ack,
  input  memAccessPkg::memOp_t op,
  input  logic                mode,
  input  logic                write,
  input  memAccessPkg::word_t resultAddress,
  input  memAccessPkg::word_t writeData,
  output memAccessPkg::word_t readData,
  output logic                stackFault,
  output logic                start,
  output memAccessPkg::memOp_t capOp,
  output logic                capMode,
  output logic                capWrite,
  output memAccessPkg::word_t capAddress,
  output memAccessPkg::word_t capWriteData,
  input  logic                done,
  input  memAccessPkg::word_t coreReadData,
  input  logic                coreFault
);

  typedef enum logic [1:0] {idle, busy, acked} portState_t;

  portState_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= idle;
      ack        <= 1'b0;
      start      <= 1'b0;
      readData   <= '0;
      stackFault <= 1'b0;
    end else begin
      start <= 1'b0; // Single-cycle pulse
      case (state)
        idle: if (req) begin
          state <= busy;
          start <= 1'b1;
        end
        busy: if (done) begin
          // Result stays put until the next request completes
          readData   <= coreReadData;
          stackFault <= coreFault;
          ack        <= 1'b1;
          state      <= acked;
        end
        acked: if (!req) begin
          ack   <= 1'b0;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // Request fields, held stable for the whole job
  always_ff @(posedge clk) begin
    if (state == idle && req) begin
      capOp        <= op;
      capMode      <= mode;
      capWrite     <= write;
      capAddress   <= resultAddress;
      capWriteData <= writeData;
    end
  end

endmodule
